// ==== hw/uart_link_macros.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART command node constants
// Clocking, line format and reply codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef UART_LINK_MACROS_SVH
`define UART_LINK_MACROS_SVH

// System clock and line rate
`define LINK_CLK_FREQ     24000000
`define LINK_BAUD         2000000
`define LINK_CLKS_PER_BIT (`LINK_CLK_FREQ / `LINK_BAUD)

// 0 selects even parity over the 8 data bits, 1 selects odd
`define LINK_PARITY_ODD   0

// Size of the nibble register file
`define LINK_NUM_REGS     4

// Reply nibbles for WRITE and for any error
`define LINK_REPLY_ACK    4'hA
`define LINK_REPLY_ERR    4'hF

`endif

// ==== hw/uart_link_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART command node shared types
// Vector widths for bytes, nibbles and syndromes,
// and the state encodings of the three FSMs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package uart_link_pkg;

    typedef logic [7:0] byte_t;      // One UART data byte (SECDED codeword)
    typedef logic [3:0] nibble_t;    // Payload or register value
    typedef logic [2:0] syndrome_t;  // Hamming syndrome, 0 means clean

    // Receiver FSM
    typedef enum logic [2:0] {
        RX_IDLE,    // Line high, waiting for falling edge
        RX_START,   // Confirming start bit at half period
        RX_DATA,    // Eight data bits, LSB first
        RX_PARITY,  // UART parity bit
        RX_STOP     // Stop bit check
    } rx_state_t;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE,    // tx held high
        TX_SEND,    // Start, data and parity bits
        TX_STOP     // Last bit period, stop bit on line
    } tx_state_t;

    // Command FSM
    typedef enum logic {
        EX_WAIT_OP,  // Next nibble is an opcode
        EX_WAIT_ARG  // Next nibble is the argument of a saved opcode
    } exec_state_t;

endpackage

// ==== hw/nibble_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded nibble link
// Carries one nibble per strobe from the SECDED
// decoder to the command stage, with error flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface nibble_if import uart_link_pkg::*; ();

    logic    valid;          // One-cycle strobe
    nibble_t data;           // Corrected payload
    logic    corrected;      // Single-bit error fixed
    logic    uncorrectable;  // Double error or bad UART frame

    // Decoder side
    modport src (
        output valid,
        output data,
        output corrected,
        output uncorrectable
    );

    // Command stage side
    modport dst (
        input valid,
        input data,
        input corrected,
        input uncorrectable
    );

endinterface

// ==== hw/uart_rx.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART receiver
// 8 data bits LSB first, parity and stop bit,
// sampled at mid-bit with a start glitch filter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "uart_link_macros.svh"

module uart_rx import uart_link_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rx,
    output byte_t data,
    output logic  done,
    output logic  frame_bad
);

    localparam int CNT_W = $clog2(`LINK_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`LINK_CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`LINK_CLKS_PER_BIT / 2 - 1);

    rx_state_t        state;
    logic             rx_meta;     // Synchronizer stages
    logic             rx_sync;
    logic [CNT_W-1:0] cnt;         // Clocks within a bit period
    logic [2:0]       bit_idx;     // Data bit being received
    logic             tick;        // Mid-bit sample point
    byte_t            shreg;
    logic             par_bit;
    logic             parity_bad;

    assign tick       = (cnt == BIT_LAST);
    assign data       = shreg;
    assign parity_bad = (^{shreg, par_bit}) != 1'(`LINK_PARITY_ODD);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;  // Idle line level
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            cnt       <= '0;
            bit_idx   <= '0;
            done      <= 1'b0;
            frame_bad <= 1'b0;
        end else begin
            done <= 1'b0;  // Strobe by default
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_sync) state <= RX_START;  // Falling edge seen
                end
                RX_START: begin
                    if (cnt == HALF_LAST) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // Still low at half bit, else a glitch
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_PARITY;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_PARITY: begin
                    if (tick) begin
                        cnt   <= '0;
                        state <= RX_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        done      <= 1'b1;
                        frame_bad <= parity_bad | ~rx_sync;  // Stop bit must be high
                        state     <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data and parity capture
    always_ff @(posedge clk) begin
        if (state == RX_DATA && tick) shreg <= {rx_sync, shreg[7:1]};  // LSB first
        if (state == RX_PARITY && tick) par_bit <= rx_sync;
    end

    a_done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("uart_rx done held for two cycles");

endmodule

// ==== hw/secded_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SECDED nibble decoder
// Hamming(7,4) plus overall parity, fixes one bit
// and flags double errors and bad frames
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module secded_decode import uart_link_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  byte_t  byte_in,
    input  logic   byte_done,
    input  logic   frame_bad,
    nibble_if.src  nib
);

    syndrome_t syn;
    logic      p_all;       // Overall parity, 1 means odd error count
    byte_t     flip_mask;
    byte_t     fixed;
    logic      corr_c;
    logic      uncorr_c;

    // Bits 0..6 are Hamming positions 1..7
    assign syn[0] = byte_in[0] ^ byte_in[2] ^ byte_in[4] ^ byte_in[6];  // Pos 1,3,5,7
    assign syn[1] = byte_in[1] ^ byte_in[2] ^ byte_in[5] ^ byte_in[6];  // Pos 2,3,6,7
    assign syn[2] = byte_in[3] ^ byte_in[4] ^ byte_in[5] ^ byte_in[6];  // Pos 4,5,6,7
    assign p_all  = ^byte_in;

    always_comb begin
        flip_mask = '0;
        corr_c    = 1'b0;
        uncorr_c  = 1'b0;
        if (frame_bad) begin
            uncorr_c = 1'b1;  // Bad UART frame overrides ECC
        end else if (syn != '0) begin
            if (p_all) begin
                flip_mask[syn - 3'd1] = 1'b1;  // Single error at position syn
                corr_c = 1'b1;
            end else begin
                uncorr_c = 1'b1;  // Two errors
            end
        end else if (p_all) begin
            corr_c = 1'b1;  // Only bit 7 hit, payload intact
        end
    end

    assign fixed = byte_in ^ flip_mask;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            nib.valid         <= 1'b0;
            nib.corrected     <= 1'b0;
            nib.uncorrectable <= 1'b0;
        end else begin
            nib.valid <= byte_done;  // Fixed 1-cycle latency
            if (byte_done) begin
                nib.corrected     <= corr_c;
                nib.uncorrectable <= uncorr_c;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_done) nib.data <= {fixed[6], fixed[5], fixed[4], fixed[2]};  // d3..d0
    end

    a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        nib.valid |-> !(nib.corrected && nib.uncorrectable))
        else $error("secded_decode corrected and uncorrectable both set");

endmodule

// ==== hw/cmd_execute.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command execute stage
// Opcode/argument FSM over a nibble register file,
// corrected-error counter and one pending reply
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "uart_link_macros.svh"

module cmd_execute import uart_link_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    nibble_if.dst   nib,
    input  logic    busy,
    output logic    reply_valid,
    output nibble_t reply
);

    localparam logic [1:0] OP_WRITE  = 2'b00;
    localparam logic [1:0] OP_READ   = 2'b01;
    localparam logic [1:0] OP_ADD    = 2'b10;
    localparam logic [1:0] OP_STATUS = 2'b11;

    exec_state_t state, state_nxt;
    nibble_t     op_q;                          // Saved opcode for WAIT_ARG
    nibble_t     regs [0:`LINK_NUM_REGS-1];
    nibble_t     corr_cnt, corr_nxt;            // Corrected nibbles mod 16
    logic        pend;
    nibble_t     pend_reply;
    logic        cmd_done;
    nibble_t     cmd_reply;
    logic        wr_en;
    nibble_t     wr_val;
    logic        issue_pend, issue_new;

    assign corr_nxt = corr_cnt + nibble_t'(nib.valid & nib.corrected);

    always_comb begin
        state_nxt = state;
        cmd_done  = 1'b0;
        cmd_reply = `LINK_REPLY_ACK;
        wr_en     = 1'b0;
        wr_val    = nib.data;
        if (nib.valid) begin
            if (nib.uncorrectable) begin
                state_nxt = EX_WAIT_OP;  // Drop any saved opcode
                cmd_done  = 1'b1;
                cmd_reply = `LINK_REPLY_ERR;
            end else if (state == EX_WAIT_OP) begin
                case (nib.data[3:2])
                    OP_WRITE, OP_ADD: state_nxt = EX_WAIT_ARG;
                    OP_READ: begin
                        cmd_done  = 1'b1;
                        cmd_reply = regs[nib.data[1:0]];
                    end
                    OP_STATUS: begin
                        cmd_done  = 1'b1;
                        cmd_reply = corr_nxt;  // Counts this nibble too
                    end
                endcase
            end else begin
                state_nxt = EX_WAIT_OP;
                cmd_done  = 1'b1;
                wr_en     = 1'b1;
                if (op_q[3:2] == OP_ADD) begin
                    wr_val    = regs[op_q[1:0]] + nib.data;  // Wraps mod 16
                    cmd_reply = wr_val;
                end
            end
        end
    end

    // Reply goes out now if the transmitter is free, else waits in pend
    assign issue_pend = pend && !busy && !reply_valid;
    assign issue_new  = cmd_done && !busy && !reply_valid && !pend;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= EX_WAIT_OP;
            corr_cnt    <= '0;
            pend        <= 1'b0;
            reply_valid <= 1'b0;
            for (int i = 0; i < `LINK_NUM_REGS; i++) regs[i] <= '0;
        end else begin
            state       <= state_nxt;
            corr_cnt    <= corr_nxt;
            reply_valid <= issue_pend | issue_new;
            if (issue_pend) pend <= 1'b0;
            if (cmd_done && !issue_new) pend <= 1'b1;  // Newer reply overwrites
            if (wr_en) regs[op_q[1:0]] <= wr_val;
        end
    end

    always_ff @(posedge clk) begin
        if (nib.valid && state == EX_WAIT_OP) op_q <= nib.data;
        if (issue_pend) reply <= pend_reply;
        else if (issue_new) reply <= cmd_reply;
        if (cmd_done && !issue_new) pend_reply <= cmd_reply;
    end

    a_no_reply_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        reply_valid |-> !busy)
        else $error("cmd_execute issued reply while transmitter busy");

endmodule

// ==== hw/reply_result.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reply encoder and UART transmitter
// SECDED-encodes the reply nibble and sends an
// 11-bit frame with start, parity and stop bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "uart_link_macros.svh"

module reply_result import uart_link_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    reply_valid,
    input  nibble_t reply,
    output logic    busy,
    output logic    tx
);

    localparam int CNT_W = $clog2(`LINK_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`LINK_CLKS_PER_BIT - 1);

    tx_state_t        state;
    logic [CNT_W-1:0] cnt;        // Clocks within a bit period
    logic [3:0]       bit_cnt;    // Bits sent after the start bit
    logic             tick;
    byte_t            cw;         // SECDED codeword
    logic             uart_par;
    logic [9:0]       shreg;      // Data, parity and stop still to send

    // Hamming(7,4): p1 over d0,d1,d3; p2 over d0,d2,d3; p4 over d1,d2,d3
    assign cw[0] = reply[0] ^ reply[1] ^ reply[3];
    assign cw[1] = reply[0] ^ reply[2] ^ reply[3];
    assign cw[2] = reply[0];
    assign cw[3] = reply[1] ^ reply[2] ^ reply[3];
    assign cw[4] = reply[1];
    assign cw[5] = reply[2];
    assign cw[6] = reply[3];
    assign cw[7] = ^cw[6:0];  // Overall parity for double detect

    assign uart_par = (^cw) ^ 1'(`LINK_PARITY_ODD);
    assign tick     = (cnt == BIT_LAST);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
            busy    <= 1'b0;
            tx      <= 1'b1;  // Line idles high
        end else begin
            case (state)
                TX_IDLE: begin
                    if (reply_valid) begin
                        tx      <= 1'b0;  // Start bit right away
                        busy    <= 1'b1;
                        cnt     <= '0;
                        bit_cnt <= '0;
                        state   <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (tick) begin
                        cnt     <= '0;
                        tx      <= shreg[0];
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'd9) state <= TX_STOP;  // Stop bit now on line
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (tick) begin
                        busy  <= 1'b0;  // End of stop bit
                        state <= TX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Frame payload, LSB first
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && reply_valid) shreg <= {1'b1, uart_par, cw};
        else if (state == TX_SEND && tick) shreg <= {1'b1, shreg[9:1]};
    end

endmodule

// ==== hw/uart_link_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial command node top level
// rx pin -> UART rx -> SECDED decode -> execute
// -> SECDED encode and UART tx -> tx pin
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module uart_link_top import uart_link_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output logic tx
);

    byte_t   rx_byte;
    logic    rx_done;
    logic    rx_frame_bad;
    logic    reply_valid;
    nibble_t reply;
    logic    tx_busy;

    nibble_if nib_bus ();  // Decode to execute

    uart_rx u_uart_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .data      (rx_byte),
        .done      (rx_done),
        .frame_bad (rx_frame_bad)
    );

    secded_decode u_secded_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .byte_in   (rx_byte),
        .byte_done (rx_done),
        .frame_bad (rx_frame_bad),
        .nib       (nib_bus.src)
    );

    cmd_execute u_cmd_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .nib         (nib_bus.dst),
        .busy        (tx_busy),
        .reply_valid (reply_valid),
        .reply       (reply)
    );

    reply_result u_reply_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .reply_valid (reply_valid),
        .reply       (reply),
        .busy        (tx_busy),
        .tx          (tx)
    );

endmodule

// ==== verif/uart_link_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART command node testbench
// Table of commands with model-computed replies,
// serial driver on rx and reply monitor on tx
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "uart_link_macros.svh"

module uart_link_tb import uart_link_pkg::*; ();

    localparam int CPB = `LINK_CLKS_PER_BIT;

    typedef struct packed {
        nibble_t op;        // Opcode nibble
        nibble_t arg;       // Argument nibble, unused by READ and STATUS
        byte_t   mask_op;   // Bit flips on the opcode codeword
        byte_t   mask_arg;  // Bit flips on the argument codeword
        logic    par_err;   // Bad UART parity on the last frame
        logic    par_op;    // Set by the model
        logic    send_arg;  // Set by the model
        nibble_t expected;  // Set by the model
    } row_t;

    logic clk;
    logic rst_n;
    logic rx;
    logic tx;

    row_t    rows[$];
    nibble_t replies[$];   // Decoded by the monitor
    int      errors = 0;
    int      checks = 0;
    int      n_replies = 0;
    int      cycles = 0;
    int      limit = 0;

    uart_link_top dut (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .tx    (tx)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("Verification failed");
            $finish;
        end
    end

    // Hamming(7,4) positions 1..7 in bits 0..6, overall parity in bit 7
    function automatic byte_t encode_codeword(nibble_t d);
        byte_t c;
        c[0] = d[0] ^ d[1] ^ d[3];  // p1 over positions 3,5,7
        c[1] = d[0] ^ d[2] ^ d[3];  // p2 over positions 3,6,7
        c[2] = d[0];
        c[3] = d[1] ^ d[2] ^ d[3];  // p4 over positions 5,6,7
        c[4] = d[1];
        c[5] = d[2];
        c[6] = d[3];
        c[7] = ^c[6:0];
        return c;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic add_row(nibble_t op, nibble_t arg, byte_t m_op, byte_t m_arg, logic pe);
        row_t r;
        r          = '0;
        r.op       = op;
        r.arg      = arg;
        r.mask_op  = m_op;
        r.mask_arg = m_arg;
        r.par_err  = pe;
        rows.push_back(r);
    endtask

    task automatic build_table();
        for (int r = 0; r < 4; r++) add_row({2'b01, 2'(r)}, 4'h0, 8'h00, 8'h00, 1'b0);
        for (int r = 0; r < 4; r++) begin
            add_row({2'b00, 2'(r)}, 4'($urandom), 8'h00, 8'h00, 1'b0);  // WRITE random
            add_row({2'b01, 2'(r)}, 4'h0, 8'h00, 8'h00, 1'b0);          // READ back
        end
        add_row(4'h1, 4'hC, 8'h00, 8'h00, 1'b0);  // WRITE r1
        add_row(4'h9, 4'h3, 8'h00, 8'h00, 1'b0);  // ADD r1 to 15
        add_row(4'h9, 4'h5, 8'h00, 8'h00, 1'b0);  // Wraps past 15
        for (int k = 0; k < 8; k++) add_row({2'b01, 2'(k)}, 4'h0, 8'(1 << k), 8'h00, 1'b0);
        add_row(4'h2, 4'h9, 8'h00, 8'h20, 1'b0);  // Flip in the argument
        add_row(4'h6, 4'h0, 8'h00, 8'h00, 1'b0);
        add_row(4'hC, 4'h0, 8'h00, 8'h00, 1'b0);  // STATUS after 9 flips
        add_row(4'hC, 4'h0, 8'h80, 8'h00, 1'b0);  // STATUS counts its own flip
        add_row(4'h3, 4'h7, 8'h00, 8'h05, 1'b0);  // Double flip in argument
        add_row(4'h7, 4'h0, 8'h00, 8'h00, 1'b0);
        add_row(4'h8, 4'h1, 8'h30, 8'h00, 1'b0);  // Double flip in opcode
        add_row(4'h4, 4'h0, 8'h00, 8'h00, 1'b0);
        add_row(4'h0, 4'h6, 8'h00, 8'h00, 1'b1);  // Bad parity on WRITE argument
        add_row(4'h4, 4'h0, 8'h00, 8'h00, 1'b0);  // r0 unchanged
        add_row(4'h5, 4'h0, 8'h00, 8'h00, 1'b1);  // Bad parity on READ opcode
        add_row(4'hC, 4'h0, 8'h00, 8'h00, 1'b0);
    endtask

    // Reference model of the command protocol, fills in the replies
    task automatic run_model();
        nibble_t regs [`LINK_NUM_REGS];
        nibble_t corr;
        row_t    r;
        logic    two_frames;
        logic    op_bad;
        logic    arg_bad;
        corr = '0;
        for (int i = 0; i < `LINK_NUM_REGS; i++) regs[i] = '0;
        foreach (rows[i]) begin
            r          = rows[i];
            two_frames = (r.op[3:2] == 2'b00) || (r.op[3:2] == 2'b10);  // WRITE, ADD
            r.par_op   = r.par_err && !two_frames;
            op_bad     = ($countones(r.mask_op) >= 2) || r.par_op;
            if (!op_bad && $countones(r.mask_op) == 1) corr++;
            r.send_arg = two_frames && !op_bad;  // Opcode dropped on error
            if (op_bad) begin
                r.expected = `LINK_REPLY_ERR;
            end else if (!two_frames) begin
                r.expected = (r.op[3:2] == 2'b01) ? regs[r.op[1:0]] : corr;
            end else begin
                arg_bad = ($countones(r.mask_arg) >= 2) || r.par_err;
                if (!arg_bad && $countones(r.mask_arg) == 1) corr++;
                if (arg_bad) begin
                    r.expected = `LINK_REPLY_ERR;
                end else if (r.op[3:2] == 2'b00) begin
                    regs[r.op[1:0]] = r.arg;
                    r.expected      = `LINK_REPLY_ACK;
                end else begin
                    regs[r.op[1:0]] = regs[r.op[1:0]] + r.arg;  // Mod 16
                    r.expected      = regs[r.op[1:0]];
                end
            end
            rows[i] = r;
        end
    endtask

    // Start, 8 data LSB first, parity, stop
    task automatic send_frame(byte_t data, logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (^data) ^ 1'(`LINK_PARITY_ODD) ^ bad_parity, data, 1'b0};
        @(negedge clk);
        for (int i = 0; i < 11; i++) begin
            rx = frame[i];
            repeat (CPB) @(negedge clk);
        end
    endtask

    task automatic monitor_replies();
        logic [9:0] bits;  // Data, parity, stop
        nibble_t    nib;
        forever begin
            @(negedge tx);
            repeat (CPB / 2) @(negedge clk);  // Middle of start bit
            if (tx !== 1'b0) begin
                errors++;
                $display("Reply start bit was not low at mid-bit");
            end
            for (int i = 0; i < 10; i++) begin
                repeat (CPB) @(negedge clk);
                bits[i] = tx;
            end
            if ((^bits[8:0]) !== 1'(`LINK_PARITY_ODD)) begin
                errors++;
                $display("Reply frame carries a wrong UART parity bit");
            end
            if (bits[9] !== 1'b1) begin
                errors++;
                $display("Reply frame has a low stop bit");
            end
            nib = {bits[6], bits[5], bits[4], bits[2]};  // d3..d0
            check_value("reply_codeword", 32'(bits[7:0]), 32'(encode_codeword(nib)));
            replies.push_back(nib);
            n_replies++;
        end
    endtask

    initial begin
        nibble_t got;
        rst_n = 1'b0;
        rx    = 1'b1;  // Idle line
        void'($urandom(32'h67dc_6b29));
        build_table();
        run_model();
        limit = rows.size() * 3 * 11 * CPB + 200;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        fork
            monitor_replies();
        join_none
        repeat (20) begin
            @(negedge clk);
            check_value("tx", 32'(tx), 32'h1);  // Idle high after reset
        end
        foreach (rows[i]) begin
            send_frame(encode_codeword(rows[i].op) ^ rows[i].mask_op, rows[i].par_op);
            if (rows[i].send_arg)
                send_frame(encode_codeword(rows[i].arg) ^ rows[i].mask_arg, rows[i].par_err);
            while (replies.size() == 0) @(negedge clk);
            got = replies.pop_front();
            check_value("reply", 32'(got), 32'(rows[i].expected));
            $display("test %0d: op %h arg %h reply %h expected %h %s", i, rows[i].op,
                     rows[i].arg, got, rows[i].expected,
                     (got === rows[i].expected) ? "ok" : "MISMATCH");
        end
        repeat (2 * CPB) @(negedge clk);
        check_value("reply_count", 32'(n_replies), 32'(rows.size()));  // No stray replies
        $display("Summary: %0d tests, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+hw
hw/uart_link_pkg.sv
hw/nibble_if.sv
hw/uart_rx.sv
hw/secded_decode.sv
hw/cmd_execute.sv
hw/reply_result.sv
hw/uart_link_top.sv
verif/uart_link_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the UART command node testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f project.f \
        --top-module uart_link_tb; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vuart_link_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "No pass message in $LOG"
    exit 1
fi
exit 0
